//--- Bender.yml
package:
  name: vstq

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vstq_addr_pkg.sv
      - rtl/vstq_msg_pkg.sv
      - rtl/vstq_bank.sv
      - rtl/vstq_read_arbiter.sv
      - rtl/vstq_stbuf_pipe.sv
      - rtl/vstq_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/vstq_assertions.sv
      - sim/tb_vstq.sv

//--- all.f
+incdir+rtl
rtl/vstq_addr_pkg.sv
rtl/vstq_msg_pkg.sv
rtl/vstq_bank.sv
rtl/vstq_read_arbiter.sv
rtl/vstq_stbuf_pipe.sv
rtl/vstq_top.sv
sim/vstq_assertions.sv
sim/tb_vstq.sv

//--- rtl/vstq_addr_pkg.sv
// Store queue address and ordering types
`include "vstq_defines.svh"

package vstq_addr_pkg;

  typedef logic [`VSTQ_TAG_W-1:0]  vstq_tag_t;
  typedef logic [`VSTQ_BANK_W-1:0] vstq_bank_t;
  typedef logic [`VSTQ_ID_W-1:0]   cmt_id_t;

  // Line view of a physical address
  typedef struct packed {
    vstq_tag_t                tag;
    vstq_bank_t               bank;    // Bits just above the offset
    logic [`VSTQ_OFS_W-1:0]   offset;
  } vstq_line_t;

  typedef union packed {
    logic [`VSTQ_PADDR_W-1:0] flat;
    vstq_line_t               line;
  } vstq_paddr_u;

  // True when a is older than b
  function automatic logic id_is_older(cmt_id_t a, cmt_id_t b);
    logic same_wrap;
    same_wrap = a[`VSTQ_ID_W-1] == b[`VSTQ_ID_W-1];
    if (same_wrap) begin
      return a[`VSTQ_ID_W-2:0] < b[`VSTQ_ID_W-2:0];
    end
    // Wrapped, so larger index was issued first
    return a[`VSTQ_ID_W-2:0] > b[`VSTQ_ID_W-2:0];
  endfunction

endpackage

//--- rtl/vstq_bank.sv
// Store queue bank
`include "vstq_defines.svh"

module vstq_bank #(
  parameter int BANK_IDX = 0
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  vstq_msg_pkg::vstq_req_t     i_req,
  input  vstq_msg_pkg::vstq_commit_t  i_commit,
  input  logic                        i_grant,
  input  vstq_msg_pkg::vstq_haz_t     i_haz,
  output logic                        o_full,
  output logic                        o_rd_req,
  output vstq_msg_pkg::vstq_rd_cand_t o_rd_cand,
  output logic                        o_haz_hit
);
  import vstq_addr_pkg::*;

  localparam int IDX_W = $clog2(`VSTQ_ENTRIES);
  localparam vstq_bank_t MY_BANK = vstq_bank_t'(BANK_IDX);

  typedef logic [IDX_W-1:0] idx_t;
  typedef enum logic [1:0] {FREE, WAIT_COMMIT, READ} state_e;

  typedef struct packed {
    cmt_id_t                 cmt_id;
    logic [`VSTQ_VREG_W-1:0] vreg;
    logic [`VSTQ_STRB_W-1:0] strb;
    vstq_tag_t               tag;
  } entry_t;

  state_e                   r_state [`VSTQ_ENTRIES];
  entry_t                   r_entry [`VSTQ_ENTRIES];
  logic [`VSTQ_ENTRIES-1:0] w_free;
  logic [`VSTQ_ENTRIES-1:0] w_alloc_oh;
  logic [`VSTQ_ENTRIES-1:0] w_read;
  logic [`VSTQ_ENTRIES-1:0] w_sel_oh;
  logic [`VSTQ_ENTRIES-1:0] w_entry_hit;
  idx_t                     r_rr_ptr;
  idx_t                     w_sel_idx;
  logic                     w_alloc;
  logic                     w_flush;
  logic                     w_req_cmt;
  logic                     w_req_hit;

  always_comb begin
    for (int i = 0; i < `VSTQ_ENTRIES; i++) begin
      w_free[i] = r_state[i] == FREE;
      w_read[i] = r_state[i] == READ;
    end
  end

  assign w_alloc_oh = w_free & (~w_free + 1'b1);   // Lowest free entry
  assign o_full     = ~|w_free;
  assign w_alloc    = i_req.valid && i_req.paddr.line.bank == MY_BANK && !o_full;
  assign w_flush    = i_commit.valid && i_commit.flush;
  assign w_req_cmt  = i_commit.valid && !i_commit.flush && i_commit.cmt_id == i_req.cmt_id;

  // ------------------------------
  // Round-robin over READ entries
  // ------------------------------
  always_comb begin
    w_sel_idx = r_rr_ptr;
    for (int i = `VSTQ_ENTRIES; i >= 1; i--) begin
      if (w_read[idx_t'(r_rr_ptr + i)]) begin
        w_sel_idx = idx_t'(r_rr_ptr + i);
      end
    end
    w_sel_oh            = '0;
    w_sel_oh[w_sel_idx] = 1'b1;
  end

  assign o_rd_req  = |w_read;
  assign o_rd_cand = '{vreg: r_entry[w_sel_idx].vreg,
                       strb: r_entry[w_sel_idx].strb,
                       tag:  r_entry[w_sel_idx].tag};

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rr_ptr <= idx_t'(`VSTQ_ENTRIES - 1);
    end else if (i_grant) begin
      r_rr_ptr <= w_sel_idx;
    end
  end

  // Entry FSMs
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < `VSTQ_ENTRIES; i++) begin
        r_state[i] <= FREE;
      end
    end else begin
      for (int i = 0; i < `VSTQ_ENTRIES; i++) begin
        case (r_state[i])
          FREE: begin
            if (w_alloc && w_alloc_oh[i] && !w_flush) begin
              r_state[i] <= w_req_cmt ? READ : WAIT_COMMIT;
            end
          end
          WAIT_COMMIT: begin
            if (w_flush) begin
              r_state[i] <= FREE;
            end else if (i_commit.valid && i_commit.cmt_id == r_entry[i].cmt_id) begin
              r_state[i] <= READ;
            end
          end
          READ: begin
            if (i_grant && w_sel_oh[i]) begin
              r_state[i] <= FREE;   // Data now owned by pipeline
            end
          end
          default: r_state[i] <= FREE;
        endcase
      end
    end
  end

  always_ff @(posedge i_clk) begin
    for (int i = 0; i < `VSTQ_ENTRIES; i++) begin
      if (w_alloc && w_alloc_oh[i]) begin
        r_entry[i] <= '{cmt_id: i_req.cmt_id, vreg: i_req.vreg,
                        strb: i_req.strb, tag: i_req.paddr.line.tag};
      end
    end
  end

  // ------------------------------
  // Scalar load hazard
  // ------------------------------
  always_comb begin
    for (int i = 0; i < `VSTQ_ENTRIES; i++) begin
      w_entry_hit[i] = r_state[i] != FREE && r_entry[i].tag == i_haz.paddr.line.tag &&
                       (r_state[i] == READ || id_is_older(r_entry[i].cmt_id, i_haz.cmt_id));
    end
  end

  assign w_req_hit = w_alloc && i_req.paddr.line.tag == i_haz.paddr.line.tag &&
                     id_is_older(i_req.cmt_id, i_haz.cmt_id);   // Store entering now
  assign o_haz_hit = i_haz.paddr.line.bank == MY_BANK && (|w_entry_hit || w_req_hit);

endmodule

//--- rtl/vstq_defines.svh
// Vector store queue sizes
`ifndef VSTQ_DEFINES_SVH
`define VSTQ_DEFINES_SVH

// ------------------------------
// Queue organisation
// ------------------------------
`define VSTQ_BANKS    4
`define VSTQ_ENTRIES  4

// ------------------------------
// Datapath widths
// ------------------------------
`define VSTQ_PADDR_W  32
`define VSTQ_DLEN_W   128
`define VSTQ_ID_W     5          // Includes wrap bit
`define VSTQ_VREG_W   6

// Derived widths
`define VSTQ_STRB_W   (`VSTQ_DLEN_W / 8)
`define VSTQ_OFS_W    $clog2(`VSTQ_STRB_W)
`define VSTQ_BANK_W   $clog2(`VSTQ_BANKS)
`define VSTQ_TAG_W    (`VSTQ_PADDR_W - `VSTQ_BANK_W - `VSTQ_OFS_W)

`endif

//--- rtl/vstq_msg_pkg.sv
// Store queue port messages
`include "vstq_defines.svh"

package vstq_msg_pkg;

  // Store request from the vector LSU
  typedef struct packed {
    logic                          valid;
    vstq_addr_pkg::cmt_id_t        cmt_id;
    logic [`VSTQ_VREG_W-1:0]       vreg;
    logic [`VSTQ_STRB_W-1:0]       strb;
    vstq_addr_pkg::vstq_paddr_u    paddr;
  } vstq_req_t;

  typedef struct packed {
    logic                          valid;
    logic                          flush;   // Drop all uncommitted
    vstq_addr_pkg::cmt_id_t        cmt_id;
  } vstq_commit_t;

  // Shared vector register read port
  typedef struct packed {
    logic                          valid;
    logic [`VSTQ_VREG_W-1:0]       vreg;
  } vrf_rd_t;

  typedef struct packed {
    logic                          valid;
    vstq_addr_pkg::vstq_paddr_u    paddr;
    logic [`VSTQ_STRB_W-1:0]       strb;
    logic [`VSTQ_DLEN_W-1:0]       data;
  } vstq_stb_t;

  // Scalar load hazard probe
  typedef struct packed {
    logic                          valid;
    vstq_addr_pkg::cmt_id_t        cmt_id;
    vstq_addr_pkg::vstq_paddr_u    paddr;
  } vstq_haz_t;

  typedef struct packed {
    logic [`VSTQ_VREG_W-1:0]       vreg;
    logic [`VSTQ_STRB_W-1:0]       strb;
    vstq_addr_pkg::vstq_tag_t      tag;
  } vstq_rd_cand_t;

endpackage

//--- rtl/vstq_read_arbiter.sv
// Bank arbiter for the register read port
`include "vstq_defines.svh"

module vstq_read_arbiter (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic [`VSTQ_BANKS-1:0]      i_rd_req,
  input  vstq_msg_pkg::vstq_rd_cand_t i_rd_cand [`VSTQ_BANKS],
  input  logic                        i_proceed,
  output logic [`VSTQ_BANKS-1:0]      o_grant,
  output vstq_msg_pkg::vrf_rd_t       o_vrf_rd,
  output vstq_msg_pkg::vstq_rd_cand_t o_sel_cand,
  output vstq_addr_pkg::vstq_bank_t   o_sel_bank
);
  import vstq_addr_pkg::*;

  vstq_bank_t r_last;
  vstq_bank_t w_sel;
  logic       w_issue;

  assign w_issue = |i_rd_req && i_proceed;

  // Next requester after last winner
  always_comb begin
    w_sel = r_last;
    for (int i = `VSTQ_BANKS; i >= 1; i--) begin
      if (i_rd_req[vstq_bank_t'(r_last + i)]) begin
        w_sel = vstq_bank_t'(r_last + i);
      end
    end
  end

  always_comb begin
    o_grant = '0;
    if (w_issue) begin
      o_grant[w_sel] = 1'b1;
    end
  end

  assign o_sel_cand     = i_rd_cand[w_sel];
  assign o_sel_bank     = w_sel;
  assign o_vrf_rd.valid = w_issue;
  assign o_vrf_rd.vreg  = o_sel_cand.vreg;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_last <= vstq_bank_t'(`VSTQ_BANKS - 1);
    end else if (w_issue) begin
      r_last <= w_sel;
    end
  end

endmodule

//--- rtl/vstq_stbuf_pipe.sv
// Store buffer output pipeline
`include "vstq_defines.svh"

module vstq_stbuf_pipe (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_issue,
  input  vstq_msg_pkg::vstq_rd_cand_t i_cand,
  input  vstq_addr_pkg::vstq_bank_t   i_bank,
  input  logic [`VSTQ_DLEN_W-1:0]     i_vrf_data,
  input  logic                        i_stb_ready,
  output logic                        o_proceed,
  output vstq_msg_pkg::vstq_stb_t     o_stb
);
  import vstq_addr_pkg::*;

  vstq_paddr_u             w_s0_paddr;
  logic                    r_s1_valid;
  vstq_paddr_u             r_s1_paddr;
  logic [`VSTQ_STRB_W-1:0] r_s1_strb;
  logic                    r_skid_valid;
  logic [`VSTQ_DLEN_W-1:0] r_skid_data;
  logic                    r_out_valid;
  vstq_paddr_u             r_out_paddr;
  logic [`VSTQ_STRB_W-1:0] r_out_strb;
  logic [`VSTQ_DLEN_W-1:0] r_out_data;

  assign o_proceed = !r_out_valid || i_stb_ready;   // Output empty or taken

  always_comb begin
    w_s0_paddr.line.tag    = i_cand.tag;
    w_s0_paddr.line.bank   = i_bank;
    w_s0_paddr.line.offset = '0;
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid   <= 1'b0;
      r_skid_valid <= 1'b0;
      r_out_valid  <= 1'b0;
    end else begin
      if (o_proceed) begin
        r_s1_valid  <= i_issue;
        r_out_valid <= r_s1_valid;
      end
      r_skid_valid <= r_s1_valid && !o_proceed;
    end
  end

  // Register data is only live the cycle after issue
  always_ff @(posedge i_clk) begin
    if (o_proceed) begin
      r_s1_paddr  <= w_s0_paddr;
      r_s1_strb   <= i_cand.strb;
      r_out_paddr <= r_s1_paddr;
      r_out_strb  <= r_s1_strb;
      r_out_data  <= r_skid_valid ? r_skid_data : i_vrf_data;
    end
    if (r_s1_valid && !o_proceed && !r_skid_valid) begin
      r_skid_data <= i_vrf_data;
    end
  end

  assign o_stb = '{valid: r_out_valid, paddr: r_out_paddr,
                   strb: r_out_strb, data: r_out_data};

endmodule

//--- rtl/vstq_top.sv
// Banked vector store queue
`include "vstq_defines.svh"

module vstq_top (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  vstq_msg_pkg::vstq_req_t    i_req,
  input  vstq_msg_pkg::vstq_commit_t i_commit,
  input  vstq_msg_pkg::vstq_haz_t    i_haz,
  input  logic [`VSTQ_DLEN_W-1:0]    i_vrf_data,
  input  logic                       i_stb_ready,
  output logic                       o_req_ready,
  output vstq_msg_pkg::vrf_rd_t      o_vrf_rd,
  output vstq_msg_pkg::vstq_stb_t    o_stb,
  output logic                       o_haz_hit
);
  import vstq_addr_pkg::*;
  import vstq_msg_pkg::*;

  logic [`VSTQ_BANKS-1:0] w_full;
  logic [`VSTQ_BANKS-1:0] w_rd_req;
  logic [`VSTQ_BANKS-1:0] w_grant;
  logic [`VSTQ_BANKS-1:0] w_bank_hit;
  vstq_rd_cand_t          w_rd_cand [`VSTQ_BANKS];
  vstq_rd_cand_t          w_sel_cand;
  vstq_bank_t             w_sel_bank;
  logic                   w_proceed;

  // ------------------------------
  // Banks
  // ------------------------------
  generate
    for (genvar b = 0; b < `VSTQ_BANKS; b++) begin : g_bank
      vstq_bank #(
        .BANK_IDX (b)
      ) u_bank (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_req     (i_req),
        .i_commit  (i_commit),
        .i_grant   (w_grant[b]),
        .i_haz     (i_haz),
        .o_full    (w_full[b]),
        .o_rd_req  (w_rd_req[b]),
        .o_rd_cand (w_rd_cand[b]),
        .o_haz_hit (w_bank_hit[b])
      );
    end
  endgenerate

  assign o_req_ready = !w_full[i_req.paddr.line.bank];
  assign o_haz_hit   = i_haz.valid && |w_bank_hit;

  vstq_read_arbiter u_arb (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_rd_req   (w_rd_req),
    .i_rd_cand  (w_rd_cand),
    .i_proceed  (w_proceed),
    .o_grant    (w_grant),
    .o_vrf_rd   (o_vrf_rd),
    .o_sel_cand (w_sel_cand),
    .o_sel_bank (w_sel_bank)
  );

  vstq_stbuf_pipe u_pipe (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_issue     (o_vrf_rd.valid),   // Read port fires only on grant
    .i_cand      (w_sel_cand),
    .i_bank      (w_sel_bank),
    .i_vrf_data  (i_vrf_data),
    .i_stb_ready (i_stb_ready),
    .o_proceed   (w_proceed),
    .o_stb       (o_stb)
  );

endmodule

//--- sim/tb_vstq.sv
// Vector store queue testbench
`include "vstq_defines.svh"

module tb_vstq;
  timeunit 1ns;
  timeprecision 1ps;
  import vstq_addr_pkg::*;
  import vstq_msg_pkg::*;

  localparam int N_RAND     = 40;
  localparam int TOTAL_OPS  = 11 + 16 + 7 + 2 * N_RAND + 5 + 3;
  localparam int MAX_CYCLES = 20 * TOTAL_OPS;

  typedef logic [`VSTQ_PADDR_W-1:0] addr_t;

  logic                    i_clk;
  logic                    i_reset_n;
  vstq_req_t               i_req;
  vstq_commit_t            i_commit;
  vstq_haz_t               i_haz;
  logic [`VSTQ_DLEN_W-1:0] i_vrf_data;
  logic                    i_stb_ready;
  logic                    o_req_ready;
  vrf_rd_t                 o_vrf_rd;
  vstq_stb_t               o_stb;
  logic                    o_haz_hit;

  // Store model, keyed by line address
  cmt_id_t                 pend_id [$];
  addr_t                   pend_addr [$];
  logic [`VSTQ_VREG_W-1:0] st_vreg [addr_t];
  logic [`VSTQ_STRB_W-1:0] st_strb [addr_t];
  logic                    exp_live [addr_t];   // Committed, not yet seen

  int      errors;
  int      test_errors;
  int      checks;
  int      tests_run;
  int      tests_failed;
  int      cycles;
  logic    rand_ready;
  cmt_id_t next_id;
  int      next_tag;
  logic                    rd_valid_q;
  logic [`VSTQ_VREG_W-1:0] rd_vreg_q;

  vstq_top uut (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_req       (i_req),
    .i_commit    (i_commit),
    .i_haz       (i_haz),
    .i_vrf_data  (i_vrf_data),
    .i_stb_ready (i_stb_ready),
    .o_req_ready (o_req_ready),
    .o_vrf_rd    (o_vrf_rd),
    .o_stb       (o_stb),
    .o_haz_hit   (o_haz_hit)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  function automatic logic [`VSTQ_DLEN_W-1:0] vreg_data(logic [`VSTQ_VREG_W-1:0] vreg);
    return {16{vreg, 2'b10}} ^ 128'h5a3c_96e1_0f7b_d248_c3a5_1e69_b784_2dc0;
  endfunction

  function automatic addr_t line_addr(int tag, int bank);
    vstq_paddr_u a;
    a.line.tag    = vstq_tag_t'(tag);
    a.line.bank   = vstq_bank_t'(bank);
    a.line.offset = '0;
    return a.flat;
  endfunction

  task automatic check_eq(string name, logic [`VSTQ_DLEN_W-1:0] exp,
                          logic [`VSTQ_DLEN_W-1:0] act);
    checks++;
    if (exp !== act) begin
      $display("FAIL %s exp=%h act=%h", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic flag_error(string msg);
    $display("%s", msg);
    errors++;
    test_errors++;
  endtask

  task automatic step();
    @(posedge i_clk);
    #1;
  endtask

  // ------------------------------
  // Register file, store buffer
  // ------------------------------
  always @(posedge i_clk) begin
    rd_valid_q = o_vrf_rd.valid;
    rd_vreg_q  = o_vrf_rd.vreg;
    #1;
    i_vrf_data  = rd_valid_q ? vreg_data(rd_vreg_q) : '0;   // One cycle after read
    i_stb_ready = rand_ready ? ($urandom_range(9) >= 3) : 1'b1;
  end

  always @(posedge i_clk) begin
    if (i_reset_n && o_stb.valid && i_stb_ready) begin
      if (exp_live.exists(o_stb.paddr.flat)) begin
        check_eq("o_stb.strb", st_strb[o_stb.paddr.flat], o_stb.strb);
        check_eq("o_stb.data", vreg_data(st_vreg[o_stb.paddr.flat]), o_stb.data);
        exp_live.delete(o_stb.paddr.flat);
      end else begin
        flag_error($sformatf("unexpected store to address %h", o_stb.paddr.flat));
      end
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles, the queue made no progress", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic send_store(input int bank, output cmt_id_t id, output addr_t addr);
    logic taken;
    id   = next_id;
    addr = line_addr(next_tag, bank);
    next_id++;
    next_tag++;
    i_req.valid      = 1'b1;
    i_req.cmt_id     = id;
    i_req.vreg       = `VSTQ_VREG_W'($urandom);
    i_req.strb       = `VSTQ_STRB_W'($urandom);
    i_req.paddr.flat = addr;
    taken = 1'b0;
    while (!taken) begin
      @(posedge i_clk);
      taken = o_req_ready;
      #1;
    end
    i_req.valid   = 1'b0;
    st_vreg[addr] = i_req.vreg;
    st_strb[addr] = i_req.strb;
    pend_id.push_back(id);
    pend_addr.push_back(addr);
  endtask

  task automatic commit_store(cmt_id_t id);
    i_commit.valid  = 1'b1;
    i_commit.flush  = 1'b0;
    i_commit.cmt_id = id;
    step();
    i_commit.valid = 1'b0;
    for (int k = 0; k < pend_id.size(); k++) begin
      if (pend_id[k] == id) begin
        exp_live[pend_addr[k]] = 1'b1;
        pend_id.delete(k);
        pend_addr.delete(k);
        break;
      end
    end
  endtask

  task automatic flush_all();
    i_commit.valid = 1'b1;
    i_commit.flush = 1'b1;
    step();
    i_commit.valid = 1'b0;
    i_commit.flush = 1'b0;
    pend_id.delete();
    pend_addr.delete();
  endtask

  // Tail cycles catch duplicates and leftovers
  task automatic drain();
    while (exp_live.num() != 0) begin
      step();
    end
    repeat (8) step();
  endtask

  task automatic check_hazard(addr_t addr, cmt_id_t id, logic exp_hit);
    i_haz.valid      = 1'b1;
    i_haz.cmt_id     = id;
    i_haz.paddr.flat = addr;
    @(posedge i_clk);
    check_eq("o_haz_hit", exp_hit, o_haz_hit);
    #1;
    i_haz.valid = 1'b0;
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("%-16s PASS", name);
    end else begin
      $display("%-16s FAIL, %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  initial begin
    addr_t   a;
    cmt_id_t id;
    cmt_id_t ids [$];
    int      pick;
    int      total;
    void'($urandom(48));
    errors      = 0;
    test_errors = 0;
    checks      = 0;
    tests_run   = 0;
    tests_failed = 0;
    cycles      = 0;
    rand_ready  = 1'b0;
    next_id     = '0;
    next_tag    = 1;
    i_reset_n   = 1'b0;
    i_req       = '0;
    i_commit    = '0;
    i_haz       = '0;
    i_vrf_data  = '0;
    i_stb_ready = 1'b1;
    repeat (16) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;

    // Queue stays idle after reset
    for (int k = 0; k < 16; k++) begin
      step();
      check_eq("o_vrf_rd.valid", 0, o_vrf_rd.valid);
      check_eq("o_stb.valid", 0, o_stb.valid);
      check_eq("o_req_ready", 1, o_req_ready);
    end

    // ------------------------------
    // Allocation and ready
    // ------------------------------
    for (int k = 0; k < 4; k++) begin
      send_store(1, id, a);
      ids.push_back(id);
    end
    i_req.valid      = 1'b1;
    i_req.paddr.flat = line_addr(next_tag, 1);
    @(posedge i_clk);
    check_eq("o_req_ready", 0, o_req_ready);   // Fifth to a full bank
    #1;
    i_req.valid = 1'b0;
    send_store(2, id, a);
    ids.push_back(id);
    while (ids.size() > 0) begin
      commit_store(ids.pop_front());
    end
    drain();
    end_test("alloc_ready");

    for (int k = 0; k < 8; k++) begin
      send_store(k % 4, id, a);
      ids.push_back(id);
    end
    while (ids.size() > 0) begin
      commit_store(ids.pop_front());
    end
    drain();
    end_test("commit_output");

    // Last two are dropped by the flush
    for (int k = 0; k < 4; k++) begin
      send_store($urandom_range(3), id, a);
      ids.push_back(id);
    end
    commit_store(ids[0]);
    commit_store(ids[1]);
    flush_all();
    ids.delete();
    drain();
    end_test("flush");

    // ------------------------------
    // Random traffic, back-pressure
    // ------------------------------
    rand_ready = 1'b1;
    for (int k = 0; k < N_RAND; k++) begin
      send_store($urandom_range(3), id, a);
      ids.push_back(id);
      if (ids.size() >= 3 || $urandom_range(1) == 1) begin
        pick = $urandom_range(ids.size() - 1);
        commit_store(ids[pick]);
        ids.delete(pick);
      end
    end
    while (ids.size() > 0) begin
      commit_store(ids.pop_front());
    end
    drain();
    rand_ready = 1'b0;
    end_test("backpressure");

    next_id = 5'd10;
    send_store(0, id, a);
    check_hazard(a + 32'h8, 5'd12, 1'b1);
    check_hazard(a + 32'h8, 5'd8, 1'b0);
    check_hazard(line_addr(next_tag, 0), 5'd12, 1'b0);
    flush_all();
    drain();
    end_test("hazard");

    // Store and load in the same cycle
    a = line_addr(next_tag, 2);
    next_tag++;
    i_req.valid      = 1'b1;
    i_req.cmt_id     = 5'd3;
    i_req.vreg       = 6'd9;
    i_req.strb       = 16'hffff;
    i_req.paddr.flat = a;
    i_haz.valid      = 1'b1;
    i_haz.cmt_id     = 5'd5;
    i_haz.paddr.flat = a + 32'h4;
    @(posedge i_clk);
    check_eq("o_req_ready", 1, o_req_ready);
    check_eq("o_haz_hit", 1, o_haz_hit);
    #1;
    i_req.valid = 1'b0;
    i_haz.valid = 1'b0;
    flush_all();
    drain();
    end_test("same_cycle_haz");

    total = errors + uut.u_assert.fail_count;
    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, checks, errors, uut.u_assert.fail_count);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- sim/vstq_assertions.sv
// Store queue port assertions
`include "vstq_defines.svh"

module vstq_assertions (
  input logic                       i_clk,
  input logic                       i_reset_n,
  input vstq_msg_pkg::vstq_req_t    i_req,
  input vstq_msg_pkg::vstq_commit_t i_commit,
  input logic                       i_stb_ready,
  input logic                       i_req_ready,
  input vstq_msg_pkg::vstq_stb_t    i_stb
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_IDS = 1 << `VSTQ_ID_W;

  int                      fail_count = 0;
  logic [N_IDS-1:0]        r_open;                // Accepted, not yet committed
  logic [`VSTQ_BANK_W-1:0] r_open_bank [N_IDS];
  int                      w_open_cnt;
  logic                    w_accept;

  assign w_accept = i_req.valid && i_req_ready;

  // Uncommitted stores by id
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_open <= '0;
    end else if (i_commit.valid && i_commit.flush) begin
      r_open <= '0;
    end else begin
      if (i_commit.valid) begin
        r_open[i_commit.cmt_id] <= 1'b0;
      end
      if (w_accept && !(i_commit.valid && i_commit.cmt_id == i_req.cmt_id)) begin
        r_open[i_req.cmt_id] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      r_open_bank[i_req.cmt_id] <= i_req.paddr.line.bank;
    end
  end

  always_comb begin
    w_open_cnt = 0;
    for (int k = 0; k < N_IDS; k++) begin
      if (r_open[k] && r_open_bank[k] == i_req.paddr.line.bank) begin
        w_open_cnt++;
      end
    end
  end

  // Output held while stalled
  a_stb_stable : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_stb.valid && !i_stb_ready |=> $stable(i_stb))
  else begin
    $error("o_stb changed while stalled");
    fail_count++;
  end

  a_quiet_after_reset : assert property (@(posedge i_clk)
    $rose(i_reset_n) |-> !i_stb.valid [*16])
  else begin
    $error("o_stb valid too soon after reset");
    fail_count++;
  end

  // Bank holding four uncommitted stores
  a_full_not_ready : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_req.valid && w_open_cnt == `VSTQ_ENTRIES |-> !i_req_ready)
  else begin
    $error("o_req_ready high for a full bank");
    fail_count++;
  end

endmodule

bind vstq_top vstq_assertions u_assert (
  .i_clk       (i_clk),
  .i_reset_n   (i_reset_n),
  .i_req       (i_req),
  .i_commit    (i_commit),
  .i_stb_ready (i_stb_ready),
  .i_req_ready (o_req_ready),
  .i_stb       (o_stb)
);
